// File: Bender.yml
package:
  name: cpu_control

sources:
  - common/cpuControlPkg.sv
  - common/decodedIf.sv
  - common/writebackIf.sv
  - source/sequenceCounter.sv
  - decode/instructionDecoder.sv
  - execute/microSequencer.sv
  - result/writebackSelect.sv
  - source/controlUnit.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/controlUnitTb.sv

// File: common/cpuControlPkg.sv
package cpuControlPkg;

    ////////////////////
    // Widths
    localparam int phaseCount   = 8;
    localparam int phaseWidth   = $clog2(phaseCount);
    localparam int opcodeWidth  = 6;
    localparam int operandWidth = 10;
    localparam int flagZ        = 3;    // Z position in the ALU flags

    // Phase indices
    localparam logic [phaseWidth-1:0] phaseFetchLow  = 3'd0;
    localparam logic [phaseWidth-1:0] phaseFetchHigh = 3'd1;
    localparam logic [phaseWidth-1:0] phaseDecode    = 3'd2;
    localparam logic [phaseWidth-1:0] phaseExec0     = 3'd3;
    localparam logic [phaseWidth-1:0] phaseExec1     = 3'd4;
    localparam logic [phaseWidth-1:0] phaseExec2     = 3'd5;
    localparam logic [phaseWidth-1:0] phaseParked    = 3'd7;    // Never used by an instruction

    ////////////////////
    // Opcodes
    localparam logic [opcodeWidth-1:0] opBra     = 6'h00;
    localparam logic [opcodeWidth-1:0] opBne     = 6'h01;
    localparam logic [opcodeWidth-1:0] opBeq     = 6'h02;
    localparam logic [opcodeWidth-1:0] opPop     = 6'h03;
    localparam logic [opcodeWidth-1:0] opPsh     = 6'h04;
    localparam logic [opcodeWidth-1:0] opAnd     = 6'h0C;
    localparam logic [opcodeWidth-1:0] opOrr     = 6'h0D;
    localparam logic [opcodeWidth-1:0] opXor     = 6'h0F;
    localparam logic [opcodeWidth-1:0] opAdd     = 6'h15;
    localparam logic [opcodeWidth-1:0] opSub     = 6'h17;
    localparam logic [opcodeWidth-1:0] opLoadImm = 6'h20;

    // ALU function codes
    localparam logic [4:0] aluAdd8 = 5'b00100;
    localparam logic [4:0] aluPass = 5'b10000;
    localparam logic [4:0] aluAdd  = 5'b10100;
    localparam logic [4:0] aluSub  = 5'b10110;
    localparam logic [4:0] aluAnd  = 5'b10111;
    localparam logic [4:0] aluOrr  = 5'b11000;
    localparam logic [4:0] aluXor  = 5'b11001;

    ////////////////////
    // Register selects, one-cold
    localparam logic [3:0] rfSelR1   = 4'b0111;
    localparam logic [3:0] rfSelR2   = 4'b1011;
    localparam logic [3:0] rfSelR3   = 4'b1101;
    localparam logic [3:0] rfSelR4   = 4'b1110;
    localparam logic [3:0] rfSelNone = 4'b1111;
    localparam logic [3:0] scrSelS1  = 4'b0111;
    localparam logic [3:0] scrSelS2  = 4'b1011;
    localparam logic [2:0] arfSelPc   = 3'b011;
    localparam logic [2:0] arfSelAr   = 3'b101;
    localparam logic [2:0] arfSelSp   = 3'b110;
    localparam logic [2:0] arfSelNone = 3'b111;

    // Function selects
    localparam logic [2:0] rfFunLoad     = 3'b010;
    localparam logic [2:0] rfFunLoadLow  = 3'b101;
    localparam logic [2:0] rfFunLoadHigh = 3'b110;
    localparam logic [2:0] arfFunDec     = 3'b000;
    localparam logic [2:0] arfFunInc     = 3'b001;
    localparam logic [2:0] arfFunLoad    = 3'b010;

    // Mux and output selects
    localparam logic [1:0] muxAAlu = 2'b00;
    localparam logic [1:0] muxAArf = 2'b01;
    localparam logic [1:0] muxAMem = 2'b10;
    localparam logic [1:0] muxAIr  = 2'b11;
    localparam logic [1:0] muxBAlu = 2'b00;
    localparam logic [1:0] muxBMem = 2'b10;
    localparam logic [1:0] outDPc  = 2'b00;
    localparam logic [1:0] outDAr  = 2'b10;
    localparam logic [1:0] outDSp  = 2'b11;
    localparam logic [1:0] outCPc  = 2'b00;
    localparam logic [2:0] outS1   = 3'b100;
    localparam logic [2:0] outS2   = 3'b101;

    ////////////////////
    typedef enum logic [2:0] {
        branchTaken, branchSkip, popOp, pushOp, loadImm, aluOp, unsupported
    } instrClass_t;

    typedef struct packed {
        logic [1:0] regSel;
        logic [7:0] immediate;
    } addressForm_t;

    typedef struct packed {
        logic       setFlags;
        logic [2:0] dstReg;
        logic [2:0] srcReg1;
        logic [2:0] srcReg2;
    } registerForm_t;

    // Low ten bits of the instruction word, read per opcode
    typedef union packed {
        addressForm_t  addressForm;
        registerForm_t registerForm;
    } operands_t;

    typedef enum logic [2:0] {
        none, irWord, scratch1, scratch2, rfReg, destReg, pc, sp
    } loadTarget_t;

    typedef enum logic [2:0] {full, lowHalf, highHalf, increment, decrement} loadKind_t;

    typedef enum logic [1:0] {alu, arf, memory, ir} loadSource_t;

endpackage

// File: common/decodedIf.sv
`timescale 1ns/1ps

interface decodedIf;
    import cpuControlPkg::*;

    // Held from the end of T2 until the next T2
    instrClass_t                instrClass;
    logic [4:0]                 aluFun;
    operands_t                  operands;
    logic [opcodeWidth-1:0]     opcode;

    modport producer (
        output instrClass,
        output aluFun,
        output operands,
        output opcode
    );

    modport consumer (
        input instrClass,
        input aluFun,
        input operands,
        input opcode
    );

endinterface

// File: common/writebackIf.sv
`timescale 1ns/1ps

interface writebackIf;
    import cpuControlPkg::*;

    loadTarget_t target;    // none when nothing loads
    loadKind_t   kind;
    loadSource_t source;
    logic        flagWrite;

    modport requester (
        output target,
        output kind,
        output source,
        output flagWrite
    );

    modport sink (
        input target,
        input kind,
        input source,
        input flagWrite
    );

endinterface

// File: decode/instructionDecoder.sv
`timescale 1ns/1ps

module instructionDecoder (
    input  logic                                 RESET,
    input  logic                                 reset,
    input  logic [cpuControlPkg::phaseWidth-1:0] phase,
    input  logic [15:0]                          irOut,
    input  logic [3:0]                           aluFlags,
    decodedIf.producer                           decoded
);
    import cpuControlPkg::*;

    logic [opcodeWidth-1:0] opcodeIn;
    operands_t              operandsIn;
    instrClass_t            classIn;
    logic                   zeroFlag;
    logic                   rfSources;

    assign opcodeIn   = irOut[15:operandWidth];
    assign operandsIn = irOut[operandWidth-1:0];
    assign zeroFlag   = aluFlags[flagZ];
    // Bit 2 set means an RF source
    assign rfSources  = operandsIn.registerForm.srcReg1[2] & operandsIn.registerForm.srcReg2[2];

    always_comb begin
        case (opcodeIn)
            opBra:     classIn = branchTaken;
            opBne:     classIn = zeroFlag ? branchSkip : branchTaken;
            opBeq:     classIn = zeroFlag ? branchTaken : branchSkip;
            opPop:     classIn = popOp;
            opPsh:     classIn = pushOp;
            opLoadImm: classIn = loadImm;
            opAnd, opOrr, opXor, opAdd, opSub: begin
                classIn = rfSources ? aluOp : unsupported;    // ARF sources dropped
            end
            default:   classIn = unsupported;
        endcase
    end

    ////////////////////
    // Capture in T2
    always_ff @(posedge RESET) begin
        if (reset) begin
            decoded.instrClass <= unsupported;
        end else if (phase == phaseDecode) begin
            decoded.instrClass <= classIn;
        end
    end

    always_ff @(posedge RESET) begin
        if (phase == phaseDecode) begin
            decoded.opcode   <= opcodeIn;
            decoded.operands <= operandsIn;
        end
    end

    // ALU code from the held opcode
    always_comb begin
        case (decoded.opcode)
            opAdd:   decoded.aluFun = aluAdd;
            opSub:   decoded.aluFun = aluSub;
            opAnd:   decoded.aluFun = aluAnd;
            opOrr:   decoded.aluFun = aluOrr;
            opXor:   decoded.aluFun = aluXor;
            default: decoded.aluFun = aluPass;
        endcase
    end

endmodule

// File: execute/microSequencer.sv
`timescale 1ns/1ps

module microSequencer (
    input  logic [cpuControlPkg::phaseWidth-1:0] phase,
    decodedIf.consumer                           decoded,
    writebackIf.requester                        wb,
    output logic                                 endOfInstruction,
    output logic [2:0]                           rfOutASel,
    output logic [2:0]                           rfOutBSel,
    output logic [4:0]                           aluFunSel,
    output logic [1:0]                           arfOutCSel,
    output logic [1:0]                           arfOutDSel,
    output logic                                 memCs,
    output logic                                 memWr,
    output logic                                 muxCSel,
    output logic                                 irWrite,
    output logic                                 irLowHigh
);
    import cpuControlPkg::*;

    logic [2:0] srcReg1;
    logic [2:0] srcReg2;
    logic [1:0] stackReg;
    logic       execPhase;

    assign srcReg1   = decoded.operands.registerForm.srcReg1;
    assign srcReg2   = decoded.operands.registerForm.srcReg2;
    assign stackReg  = decoded.operands.addressForm.regSel;
    assign execPhase = (phase == phaseExec0) || (phase == phaseExec1) || (phase == phaseExec2);

    always_comb begin
        // Idle values
        endOfInstruction = 1'b0;
        rfOutASel        = '0;
        rfOutBSel        = '0;
        aluFunSel        = '0;
        arfOutCSel       = '0;
        arfOutDSel       = '0;
        memCs            = 1'b1;    // Memory deselected (active low)
        memWr            = 1'b0;
        muxCSel          = 1'b0;
        irWrite          = 1'b0;
        irLowHigh        = 1'b0;
        wb.target        = none;
        wb.kind          = full;
        wb.source        = alu;
        wb.flagWrite     = 1'b0;

        ////////////////////
        // Fetch of low byte then high byte
        if (phase == phaseFetchLow || phase == phaseFetchHigh) begin
            arfOutDSel = outDPc;
            memCs      = 1'b0;
            irWrite    = 1'b1;
            irLowHigh  = (phase == phaseFetchHigh);
            wb.target  = irWord;    // PC steps with it
            wb.source  = memory;
        end else if (execPhase) begin
            case (decoded.instrClass)
                branchTaken: begin
                    if (phase == phaseExec0) begin    // S1 <- PC
                        arfOutCSel = outCPc;
                        wb.target  = scratch1;
                        wb.source  = arf;
                    end else if (phase == phaseExec1) begin    // S2 <- IR offset
                        wb.target = scratch2;
                        wb.source = ir;
                    end else begin    // PC <- S1 + S2
                        rfOutASel        = outS1;
                        rfOutBSel        = outS2;
                        aluFunSel        = aluAdd8;
                        wb.target        = pc;
                        endOfInstruction = 1'b1;
                    end
                end
                popOp, pushOp: begin
                    if (phase != phaseExec2) begin
                        arfOutDSel       = outDSp;
                        memCs            = 1'b0;
                        endOfInstruction = (phase == phaseExec1);
                        if (decoded.instrClass == popOp) begin
                            wb.target = rfReg;    // SP steps up with it
                            wb.kind   = (phase == phaseExec0) ? lowHalf : highHalf;
                            wb.source = memory;
                        end else begin
                            memWr     = 1'b1;
                            rfOutASel = {1'b0, stackReg};
                            aluFunSel = aluPass;
                            muxCSel   = (phase == phaseExec1);    // Low byte first
                            wb.target = sp;
                            wb.kind   = decrement;
                        end
                    end
                end
                loadImm: begin
                    if (phase == phaseExec0) begin
                        wb.target        = rfReg;
                        wb.kind          = lowHalf;
                        wb.source        = ir;
                        endOfInstruction = 1'b1;
                    end
                end
                aluOp: begin
                    if (phase != phaseExec2) begin
                        rfOutASel = {1'b0, srcReg1[1:0]};
                        rfOutBSel = {1'b0, srcReg2[1:0]};
                        aluFunSel = decoded.aluFun;
                        if (phase == phaseExec1) begin
                            wb.target        = destReg;
                            wb.flagWrite     = decoded.operands.registerForm.setFlags;
                            endOfInstruction = 1'b1;
                        end
                    end
                end
                // Skipped branches and unsupported forms idle through T3
                default: endOfInstruction = (phase == phaseExec0);
            endcase
        end
    end

endmodule

// File: filelist.f
+incdir+verif
common/cpuControlPkg.sv
common/decodedIf.sv
common/writebackIf.sv
source/sequenceCounter.sv
decode/instructionDecoder.sv
execute/microSequencer.sv
result/writebackSelect.sv
source/controlUnit.sv
verif/controlUnitTb.sv

// File: result/writebackSelect.sv
`timescale 1ns/1ps

module writebackSelect (
    decodedIf.consumer  decoded,
    writebackIf.sink    wb,
    output logic [3:0]  rfRegSel,
    output logic [3:0]  rfScrSel,
    output logic [2:0]  rfFunSel,
    output logic [2:0]  arfRegSel,
    output logic [2:0]  arfFunSel,
    output logic [1:0]  muxASel,
    output logic [1:0]  muxBSel,
    output logic        wf
);
    import cpuControlPkg::*;

    logic [2:0] dstReg;

    assign dstReg = decoded.operands.registerForm.dstReg;

    function automatic logic [3:0] rfOneCold(input logic [1:0] index);
        case (index)
            2'd0:    return rfSelR1;
            2'd1:    return rfSelR2;
            2'd2:    return rfSelR3;
            default: return rfSelR4;
        endcase
    endfunction

    function automatic logic [2:0] rfFunCode(input loadKind_t kind);
        case (kind)
            lowHalf:  return rfFunLoadLow;
            highHalf: return rfFunLoadHigh;
            default:  return rfFunLoad;
        endcase
    endfunction

    function automatic logic [2:0] arfFunCode(input loadKind_t kind);
        case (kind)
            increment: return arfFunInc;
            decrement: return arfFunDec;
            default:   return arfFunLoad;
        endcase
    endfunction

    function automatic logic [1:0] muxACode(input loadSource_t source);
        case (source)
            arf:     return muxAArf;
            memory:  return muxAMem;
            ir:      return muxAIr;
            default: return muxAAlu;
        endcase
    endfunction

    always_comb begin
        rfRegSel  = rfSelNone;
        rfScrSel  = rfSelNone;
        rfFunSel  = '0;
        arfRegSel = arfSelNone;
        arfFunSel = '0;
        muxASel   = '0;
        muxBSel   = '0;

        case (wb.target)
            irWord: begin    // IR load strobed by the sequencer, PC steps
                arfRegSel = arfSelPc;
                arfFunSel = arfFunInc;
            end
            scratch1, scratch2: begin
                rfScrSel = (wb.target == scratch1) ? scrSelS1 : scrSelS2;
                rfFunSel = rfFunCode(wb.kind);
                muxASel  = muxACode(wb.source);
            end
            rfReg: begin
                rfRegSel = rfOneCold(decoded.operands.addressForm.regSel);
                rfFunSel = rfFunCode(wb.kind);
                muxASel  = muxACode(wb.source);
                if (wb.source == memory) begin    // Stack read, SP moves up
                    arfRegSel = arfSelSp;
                    arfFunSel = arfFunInc;
                end
            end
            destReg: begin
                if (dstReg[2]) begin    // RF destination
                    rfRegSel = rfOneCold(dstReg[1:0]);
                    rfFunSel = rfFunCode(wb.kind);
                    muxASel  = muxACode(wb.source);
                end else begin
                    case (dstReg[1:0])
                        2'b10:   arfRegSel = arfSelSp;
                        2'b11:   arfRegSel = arfSelAr;
                        default: arfRegSel = arfSelPc;
                    endcase
                    arfFunSel = arfFunCode(wb.kind);
                    muxBSel   = (wb.source == memory) ? muxBMem : muxBAlu;
                end
            end
            pc, sp: begin
                arfRegSel = (wb.target == pc) ? arfSelPc : arfSelSp;
                arfFunSel = arfFunCode(wb.kind);
                muxBSel   = (wb.source == memory) ? muxBMem : muxBAlu;
            end
            default: ;
        endcase
    end

    assign wf = wb.flagWrite;

endmodule

// File: source/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
    input  logic                                 RESET,
    input  logic                                 reset,
    input  logic [15:0]                          irOut,
    input  logic [3:0]                           aluFlags,
    output logic [cpuControlPkg::phaseCount-1:0] timing,
    output logic [2:0]                           rfOutASel,
    output logic [2:0]                           rfOutBSel,
    output logic [2:0]                           rfFunSel,
    output logic [3:0]                           rfRegSel,
    output logic [3:0]                           rfScrSel,
    output logic [4:0]                           aluFunSel,
    output logic [1:0]                           arfOutCSel,
    output logic [1:0]                           arfOutDSel,
    output logic [2:0]                           arfFunSel,
    output logic [2:0]                           arfRegSel,
    output logic [1:0]                           muxASel,
    output logic [1:0]                           muxBSel,
    output logic                                 muxCSel,
    output logic                                 memCs,
    output logic                                 memWr,
    output logic                                 irWrite,
    output logic                                 irLowHigh,
    output logic                                 wf
);
    import cpuControlPkg::*;

    logic [phaseWidth-1:0] phase;
    logic                  endOfInstruction;

    decodedIf   decodedBus ();
    writebackIf writebackBus ();

    sequenceCounter seqCounter (
        .RESET  (RESET),
        .reset  (reset),
        .clear  (endOfInstruction),
        .phase  (phase),
        .timing (timing)
    );

    instructionDecoder decoder (
        .RESET    (RESET),
        .reset    (reset),
        .phase    (phase),
        .irOut    (irOut),
        .aluFlags (aluFlags),
        .decoded  (decodedBus.producer)
    );

    ////////////////////
    // Read side, memory strobes and load requests
    microSequencer sequencer (
        .phase            (phase),
        .decoded          (decodedBus.consumer),
        .wb               (writebackBus.requester),
        .endOfInstruction (endOfInstruction),
        .rfOutASel        (rfOutASel),
        .rfOutBSel        (rfOutBSel),
        .aluFunSel        (aluFunSel),
        .arfOutCSel       (arfOutCSel),
        .arfOutDSel       (arfOutDSel),
        .memCs            (memCs),
        .memWr            (memWr),
        .muxCSel          (muxCSel),
        .irWrite          (irWrite),
        .irLowHigh        (irLowHigh)
    );

    writebackSelect writeback (
        .decoded   (decodedBus.consumer),
        .wb        (writebackBus.sink),
        .rfRegSel  (rfRegSel),
        .rfScrSel  (rfScrSel),
        .rfFunSel  (rfFunSel),
        .arfRegSel (arfRegSel),
        .arfFunSel (arfFunSel),
        .muxASel   (muxASel),
        .muxBSel   (muxBSel),
        .wf        (wf)
    );

endmodule

// File: source/sequenceCounter.sv
`timescale 1ns/1ps

module sequenceCounter (
    input  logic                                 RESET,
    input  logic                                 reset,
    input  logic                                 clear,
    output logic [cpuControlPkg::phaseWidth-1:0] phase,
    output logic [cpuControlPkg::phaseCount-1:0] timing
);
    import cpuControlPkg::*;

    // Reset parks the count in the unused last phase,
    // so the first edge after reset wraps it to T0
    always_ff @(posedge RESET) begin
        if (reset) begin
            phase <= phaseParked;
        end else if (clear) begin
            phase <= phaseFetchLow;    // Next instruction
        end else begin
            phase <= phase + 1'b1;
        end
    end

    assign timing = {{(phaseCount - 1){1'b0}}, 1'b1} << phase;    // One-hot T0 to T7

endmodule

// File: verif/controlUnitTests.svh
// Every instruction task starts at the drive point of its T0

task automatic resetBehavior;
    int n;
    for (n = 0; n < resetCycles; n++) begin
        waitEdge();
        expectIdle();
        compareOutputs("reset held");
    end
    reset = 1'b0;
    expectIdle();
    compareOutputs("reset released");
    waitEdge();    // First edge after release gives T0
endtask

// T0 and T1 fetch, then the idle decode phase
task automatic fetchPhases(input string name, input logic [15:0] word, input logic [3:0] flags);
    int t;
    irOut    = word;
    aluFlags = flags;
    for (t = 0; t < 2; t++) begin
        expectIdle();
        expArfOutD   = outDPc;
        expMemCs     = 1'b0;
        expIrWrite   = 1'b1;
        expIrLowHigh = (t == 1);
        expArfReg    = arfSelPc;    // PC increments
        expArfFun    = arfFunInc;
        checkCycle(name, t);
    end
    expectIdle();
    checkCycle(name, 2);
endtask

task automatic aluInstruction(input logic [5:0] opcode, input logic [4:0] code, input logic s,
                              input logic [2:0] dst, input logic [2:0] src1,
                              input logic [2:0] src2);
    string name;
    int    t;
    name = $sformatf("alu op %h dst %b", opcode, dst);
    fetchPhases(name, {opcode, s, dst, src1, src2}, 4'h0);
    for (t = 3; t <= 4; t++) begin
        expectIdle();
        expRfOutA = {1'b0, src1[1:0]};
        expRfOutB = {1'b0, src2[1:0]};
        expAluFun = code;
        if (t == 4) begin
            if (dst[2]) begin
                expRfReg = oneCold(dst[1:0]);
                expRfFun = rfFunLoad;
                expMuxA  = muxAAlu;
            end else begin
                expArfReg = arfDestSelect(dst[1:0]);
                expArfFun = arfFunLoad;
                expMuxB   = muxBAlu;
            end
            expWf = s;
        end
        checkCycle(name, t);
    end
    checkPhase(name, 0);
endtask

task automatic aluOperations;
    logic [5:0] opcodes [5];
    logic [4:0] codes [5];
    int         k;
    int         d;
    opcodes = '{opAdd, opSub, opAnd, opOrr, opXor};
    codes   = '{aluAdd, aluSub, aluAnd, aluOrr, aluXor};
    for (k = 0; k < 5; k++) begin
        for (d = 0; d < 2; d++) begin    // RF then ARF destination
            aluInstruction(opcodes[k], codes[k], 1'((k + d) % 2),
                           (d == 0) ? {1'b1, 2'(3 - k)} : {1'b0, k[1:0]},
                           {1'b1, k[1:0]}, {1'b1, 2'(k + 1)});
        end
    end
endtask

task automatic branchInstruction(input logic [5:0] opcode, input logic z);
    string name;
    logic  taken;
    name  = $sformatf("branch op %h z %b", opcode, z);
    taken = (opcode == opBra) || (opcode == opBne && !z) || (opcode == opBeq && z);
    fetchPhases(name, {opcode, 10'h0A5}, {z, 3'b101});
    expectIdle();
    if (taken) begin
        expArfOutC = outCPc;    // S1 from PC
        expRfScr   = scrSelS1;
        expRfFun   = rfFunLoad;
        expMuxA    = muxAArf;
        checkCycle(name, 3);
        expectIdle();
        expRfScr = scrSelS2;    // S2 from IR
        expRfFun = rfFunLoad;
        expMuxA  = muxAIr;
        checkCycle(name, 4);
        expectIdle();
        expRfOutA = outS1;
        expRfOutB = outS2;
        expAluFun = aluAdd8;
        expMuxB   = muxBAlu;
        expArfReg = arfSelPc;
        expArfFun = arfFunLoad;
        checkCycle(name, 5);
    end else begin
        checkCycle(name, 3);
    end
    checkPhase(name, 0);
endtask

task automatic branchOutcomes;
    branchInstruction(opBra, 1'b0);
    branchInstruction(opBra, 1'b1);
    branchInstruction(opBne, 1'b0);
    branchInstruction(opBne, 1'b1);
    branchInstruction(opBeq, 1'b0);
    branchInstruction(opBeq, 1'b1);
endtask

task automatic stackInstruction(input logic push, input logic [1:0] regSel);
    string name;
    int    t;
    name = $sformatf("%s r%0d", push ? "push" : "pop", regSel + 1);
    fetchPhases(name, {push ? opPsh : opPop, regSel, 8'h3C}, 4'h0);
    for (t = 3; t <= 4; t++) begin
        expectIdle();
        expArfOutD = outDSp;
        expMemCs   = 1'b0;
        expArfReg  = arfSelSp;
        if (push) begin
            expMemWr  = 1'b1;
            expRfOutA = {1'b0, regSel};
            expAluFun = aluPass;
            expMuxC   = (t == 4);
            expArfFun = arfFunDec;
            expMuxB   = muxBAlu;
        end else begin
            expRfReg  = oneCold(regSel);
            expRfFun  = (t == 3) ? rfFunLoadLow : rfFunLoadHigh;
            expMuxA   = muxAMem;
            expArfFun = arfFunInc;
        end
        checkCycle(name, t);
    end
    checkPhase(name, 0);
endtask

task automatic stackTransfers;
    int r;
    for (r = 0; r < 4; r++) begin
        stackInstruction(1'b1, r[1:0]);
        stackInstruction(1'b0, r[1:0]);
    end
endtask

task automatic immediateLoads;
    string name;
    int    r;
    for (r = 0; r < 4; r++) begin
        name = $sformatf("load immediate r%0d", r + 1);
        fetchPhases(name, {opLoadImm, r[1:0], 8'h5A ^ 8'(r * 37)}, 4'h0);
        expectIdle();
        expRfReg = oneCold(r[1:0]);
        expRfFun = rfFunLoadLow;
        expMuxA  = muxAIr;
        checkCycle(name, 3);
        checkPhase(name, 0);
    end
endtask

// ALU forms naming an ARF source idle through T3
task automatic unsupportedForms;
    fetchPhases("unsupported add", {opAdd, 1'b1, 3'b100, 3'b001, 3'b101}, 4'h0);
    expectIdle();
    checkCycle("unsupported add", 3);
    checkPhase("unsupported add", 0);
    fetchPhases("unsupported xor", {opXor, 1'b0, 3'b010, 3'b110, 3'b010}, 4'h0);
    expectIdle();
    checkCycle("unsupported xor", 3);
    checkPhase("unsupported xor", 0);
endtask

// File: verif/controlUnitTb.sv
`timescale 1ns/1ps

module controlUnitTb;
    import cpuControlPkg::*;

    localparam int clockPeriod  = 8;
    localparam int resetCycles  = 8;
    localparam int driveDelay   = 1;
    // Reset, ten ALU forms, six branches, eight stack moves, four immediates, two rejects
    localparam int testCycles   = resetCycles + 1 + 10 * 5 + 6 * 6 + 8 * 5 + 4 * 4 + 2 * 4;
    localparam int marginCycles = 40;

    logic        RESET;
    logic        reset;
    logic [15:0] irOut;
    logic [3:0]  aluFlags;
    logic [7:0]  timing;
    logic [2:0]  rfOutASel, rfOutBSel, rfFunSel, arfFunSel, arfRegSel;
    logic [3:0]  rfRegSel, rfScrSel;
    logic [4:0]  aluFunSel;
    logic [1:0]  arfOutCSel, arfOutDSel, muxASel, muxBSel;
    logic        muxCSel, memCs, memWr, irWrite, irLowHigh, wf;

    // Expected values for the current phase
    logic [2:0]  expRfOutA, expRfOutB, expRfFun, expArfFun, expArfReg;
    logic [3:0]  expRfReg, expRfScr;
    logic [4:0]  expAluFun;
    logic [1:0]  expArfOutC, expArfOutD, expMuxA, expMuxB;
    logic        expMuxC, expMemCs, expMemWr, expIrWrite, expIrLowHigh, expWf;

    int checkCount;
    int errorCount;

    controlUnit i_dut (
        .RESET      (RESET),
        .reset      (reset),
        .irOut      (irOut),
        .aluFlags   (aluFlags),
        .timing     (timing),
        .rfOutASel  (rfOutASel),
        .rfOutBSel  (rfOutBSel),
        .rfFunSel   (rfFunSel),
        .rfRegSel   (rfRegSel),
        .rfScrSel   (rfScrSel),
        .aluFunSel  (aluFunSel),
        .arfOutCSel (arfOutCSel),
        .arfOutDSel (arfOutDSel),
        .arfFunSel  (arfFunSel),
        .arfRegSel  (arfRegSel),
        .muxASel    (muxASel),
        .muxBSel    (muxBSel),
        .muxCSel    (muxCSel),
        .memCs      (memCs),
        .memWr      (memWr),
        .irWrite    (irWrite),
        .irLowHigh  (irLowHigh),
        .wf         (wf)
    );

    always #(clockPeriod / 2) RESET = ~RESET;

    ////////////////////
    // Checking helpers
    task automatic waitEdge;
        @(posedge RESET);
        #driveDelay;    // Drive and sample point
    endtask

    task automatic expectIdle;
        expRfOutA    = '0;
        expRfOutB    = '0;
        expRfFun     = '0;
        expRfReg     = rfSelNone;
        expRfScr     = rfSelNone;
        expAluFun    = '0;
        expArfOutC   = '0;
        expArfOutD   = '0;
        expArfFun    = '0;
        expArfReg    = arfSelNone;
        expMuxA      = '0;
        expMuxB      = '0;
        expMuxC      = 1'b0;
        expMemCs     = 1'b1;
        expMemWr     = 1'b0;
        expIrWrite   = 1'b0;
        expIrLowHigh = 1'b0;
        expWf        = 1'b0;
    endtask

    task automatic checkField(input string name, input string field,
                              input logic [7:0] expected, input logic [7:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Mismatch in %s, %s: expected %h, actual %h", name, field, expected, actual);
        end
    endtask

    task automatic compareOutputs(input string name);
        checkField(name, "rfOutASel", expRfOutA, rfOutASel);
        checkField(name, "rfOutBSel", expRfOutB, rfOutBSel);
        checkField(name, "rfFunSel", expRfFun, rfFunSel);
        checkField(name, "rfRegSel", expRfReg, rfRegSel);
        checkField(name, "rfScrSel", expRfScr, rfScrSel);
        checkField(name, "aluFunSel", expAluFun, aluFunSel);
        checkField(name, "arfOutCSel", expArfOutC, arfOutCSel);
        checkField(name, "arfOutDSel", expArfOutD, arfOutDSel);
        checkField(name, "arfFunSel", expArfFun, arfFunSel);
        checkField(name, "arfRegSel", expArfReg, arfRegSel);
        checkField(name, "muxASel", expMuxA, muxASel);
        checkField(name, "muxBSel", expMuxB, muxBSel);
        checkField(name, "muxCSel", expMuxC, muxCSel);
        checkField(name, "memCs", expMemCs, memCs);
        checkField(name, "memWr", expMemWr, memWr);
        checkField(name, "irWrite", expIrWrite, irWrite);
        checkField(name, "irLowHigh", expIrLowHigh, irLowHigh);
        checkField(name, "wf", expWf, wf);
    endtask

    task automatic checkPhase(input string name, input int index);
        checkField(name, "timing", 8'b1 << index, timing);
    endtask

    // Check the current phase, then move to the next cycle
    task automatic checkCycle(input string name, input int index);
        checkPhase(name, index);
        compareOutputs(name);
        waitEdge();
    endtask

    function automatic logic [3:0] oneCold(input logic [1:0] index);
        return ~(4'b1000 >> index);    // R1 is the top bit
    endfunction

    function automatic logic [2:0] arfDestSelect(input logic [1:0] code);
        case (code)
            2'b10:   return arfSelSp;
            2'b11:   return arfSelAr;
            default: return arfSelPc;
        endcase
    endfunction

    `include "controlUnitTests.svh"

    ////////////////////
    initial begin
        RESET      = 1'b0;
        reset      = 1'b1;
        irOut      = '0;
        aluFlags   = '0;
        checkCount = 0;
        errorCount = 0;

        resetBehavior();
        aluOperations();
        branchOutcomes();
        stackTransfers();
        immediateLoads();
        unsupportedForms();

        $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #((testCycles + marginCycles) * clockPeriod);
        $display("Timeout: the tests did not finish within %0d cycles",
                 testCycles + marginCycles);
        $display("Done: errors found");
        $finish;
    end

endmodule
